/* xoodyak_macros.svh */
`ifndef XOODYAK_MACROS_SVH
`define XOODYAK_MACROS_SVH

// ------------------------------
// Xoodoo state geometry
// ------------------------------
`define XOO_STATE_W             384
`define XOO_PLANE_W             128
`define XOO_LANE_W              32

// Cyclist data widths
`define XOO_DATA_W              352
`define XOO_TEXT_W              192

// Permutation schedule
`define XOO_ROUNDS              12
`define XOO_ROUNDS_PER_CLK      3

// ------------------------------
// Opcodes carried on opmode[3:0]
// ------------------------------
`define OP_NOP                  4'd0
`define OP_CYC                  4'd1
`define OP_ABS                  4'd3
`define OP_ENC                  4'd4
`define OP_DEC                  4'd5
`define OP_SQZ                  4'd6

`endif

/* xoodyak_pkg.sv */
`include "xoodyak_macros.svh"

package xoodyak_pkg;

        // Full state, plane y at [128y+127:128y], lane x at [32x+31:32x] in a plane
        typedef logic [`XOO_STATE_W-1:0] xoo_state_t;

        // Command word as seen on opmode
        typedef struct packed {
                // Bit 4 picks hash mode on cyclist
                logic       hash_sel;
                logic [3:0] op;
        } xoo_cmd_t;

        // Cyclist mode, none until the first cyclist command
        typedef enum logic [1:0] {
                MODE_NONE  = 2'd0,
                MODE_HASH  = 2'd1,
                MODE_KEYED = 2'd2
        } xoo_mode_t;

        // Control to datapath
        typedef struct packed {
                // Load the initial cyclist state
                logic       load_cyc;
                // First cycle of a permutation
                logic       perm_go;
                // Op being worked on
                logic [3:0] op;
                // Op differs from the last completed one
                logic       new_op;
                xoo_mode_t  mode;
        } xoo_ctrl_t;

        // Round constants, entry 0 used by the first round
        parameter logic [`XOO_ROUNDS-1:0][11:0] xoo_rc_table = {
                12'h012, 12'h1A0, 12'h0F0, 12'h380,
                12'h02C, 12'h060, 12'h014, 12'h120,
                12'h0D0, 12'h3C0, 12'h038, 12'h058
        };

endpackage

/* xoodoo_round.sv */
`timescale 1ns/1ps
`include "xoodyak_macros.svh"

module xoodoo_round (
        input  logic [11:0]             rc,
        input  xoodyak_pkg::xoo_state_t state_in,
        output xoodyak_pkg::xoo_state_t state_out
);

        localparam int LANES = `XOO_PLANE_W / `XOO_LANE_W;

        // One plane as [x][z]
        typedef logic [LANES-1:0][`XOO_LANE_W-1:0] plane_t;

        // Plane shift by (dx, dz)
        // Lane i lands on lane i+dx, each lane rotated left by dz
        function automatic plane_t rot(input plane_t pl, input int dx, input int dz);
                plane_t r;
                for (int i = 0; i < LANES; i++) begin
                        r[(i + dx) % LANES] = (pl[i] << dz) | (pl[i] >> (`XOO_LANE_W - dz));
                end
                return r;
        endfunction

        // State as [y][x][z]
        plane_t [2:0] a_in;
        plane_t [2:0] a_th;
        plane_t [2:0] a_rw;
        plane_t [2:0] a_chi;
        plane_t [2:0] a_re;
        plane_t       p;
        plane_t       e;

        assign a_in = state_in;

        // ------------------------------
        // Theta
        // ------------------------------
        // Column parity
        assign p = a_in[0] ^ a_in[1] ^ a_in[2];
        // Parity spread over two neighbouring columns
        assign e = rot(p, 1, 5) ^ rot(p, 1, 14);

        assign a_th[0] = a_in[0] ^ e;
        assign a_th[1] = a_in[1] ^ e;
        assign a_th[2] = a_in[2] ^ e;

        // Rho west, iota folded into plane 0
        // Constant sits on z = 0 upwards of lane 0
        assign a_rw[0] = a_th[0] ^ {{(`XOO_PLANE_W - 12){1'b0}}, rc};
        assign a_rw[1] = rot(a_th[1], 1, 0);
        assign a_rw[2] = rot(a_th[2], 0, 11);

        // ------------------------------
        // Chi
        // ------------------------------
        // B0 = ~A1 & A2, B1 = ~A2 & A0, B2 = ~A0 & A1
        assign a_chi[0] = a_rw[0] ^ (~a_rw[1] & a_rw[2]);
        assign a_chi[1] = a_rw[1] ^ (~a_rw[2] & a_rw[0]);
        assign a_chi[2] = a_rw[2] ^ (~a_rw[0] & a_rw[1]);

        // Rho east, plane 0 untouched
        assign a_re[0] = a_chi[0];
        assign a_re[1] = rot(a_chi[1], 0, 1);
        assign a_re[2] = rot(a_chi[2], 2, 8);

        assign state_out = a_re;

endmodule

/* xoodoo_permute.sv */
`timescale 1ns/1ps
`include "xoodyak_macros.svh"

module xoodoo_permute (
        input  logic                    eph1,
        input  logic                    rst_n,
        input  logic                    go,
        input  xoodyak_pkg::xoo_state_t state_in,
        output xoodyak_pkg::xoo_state_t state_out,
        output logic                    done
);
        import xoodyak_pkg::*;

        // Clocks per permutation
        localparam int N_GRP = `XOO_ROUNDS / `XOO_ROUNDS_PER_CLK;

        logic       busy;
        logic [1:0] grp;
        logic [3:0] rc_base;
        xoo_state_t st_q;
        xoo_state_t chain [`XOO_ROUNDS_PER_CLK + 1];

        // First round of the current group, 3 * grp
        assign rc_base = {2'b00, grp} + {1'b0, grp, 1'b0};

        // ------------------------------
        // Round chain
        // ------------------------------
        assign chain[0] = st_q;

        for (genvar k = 0; k < `XOO_ROUNDS_PER_CLK; k++) begin : g_rnd
                xoodoo_round u_rnd (
                        .rc        (xoo_rc_table[rc_base + 4'(k)]),
                        .state_in  (chain[k]),
                        .state_out (chain[k + 1])
                );
        end

        // Unregistered, valid as a result only while done is high
        assign state_out = chain[`XOO_ROUNDS_PER_CLK];

        // Last group in flight
        assign done = busy && (grp == 2'(N_GRP - 1));

        // Group counter
        always_ff @(posedge eph1 or negedge rst_n) begin
                if (!rst_n) begin
                        busy <= 1'b0;
                        grp  <= 2'd0;
                end else if (go) begin
                        busy <= 1'b1;
                        grp  <= 2'd0;
                end else if (busy) begin
                        grp <= grp + 2'd1;
                        if (done) begin
                                busy <= 1'b0;
                        end
                end
        end

        // Working state, loaded on go then recirculated
        always_ff @(posedge eph1) begin
                if (go) begin
                        st_q <= state_in;
                end else if (busy) begin
                        st_q <= chain[`XOO_ROUNDS_PER_CLK];
                end
        end

        // Start only once the previous permutation has finished
        a_go_idle: assert property (@(posedge eph1) disable iff (!rst_n) go |-> !busy);

endmodule

/* cyclist_ctrl.sv */
`timescale 1ns/1ps
`include "xoodyak_macros.svh"

module cyclist_ctrl (
        input  logic                   eph1,
        input  logic                   rst_n,
        input  xoodyak_pkg::xoo_cmd_t  cmd,
        input  logic                   perm_done,
        output xoodyak_pkg::xoo_ctrl_t ctrl,
        output logic                   ready,
        output logic                   textout_valid
);
        import xoodyak_pkg::*;

        // One-hot FSM bit positions
        localparam int S_IDLE = 0;
        localparam int S_CYC  = 1;
        localparam int S_RUN  = 2;

        logic [2:0] fsm_q;
        logic [2:0] fsm_d;
        xoo_mode_t  mode_q;
        logic [3:0] op_q;
        // Last completed op
        // Cleared to nop by cyclist
        logic [3:0] prev_q;
        logic       go_q;
        logic       tv_q;
        logic       legal;
        logic       accept;
        logic       is_text;
        logic       finish;

        // ------------------------------
        // Command decode
        // ------------------------------
        always_comb begin
                case (cmd.op)
                        `OP_CYC: legal = 1'b1;
                        `OP_ABS,
                        `OP_SQZ: legal = (mode_q != MODE_NONE);
                        `OP_ENC,
                        `OP_DEC: legal = (mode_q == MODE_KEYED);
                        default: legal = 1'b0;
                endcase
        end

        assign ready   = fsm_q[S_IDLE];
        assign accept  = ready && legal;
        assign finish  = fsm_q[S_RUN] && perm_done;
        // Ops that put text on textout
        assign is_text = op_q inside {`OP_ENC, `OP_DEC, `OP_SQZ};

        // Next state
        always_comb begin
                fsm_d = fsm_q;
                if (fsm_q[S_IDLE] && accept) begin
                        fsm_d = (cmd.op == `OP_CYC) ? 3'(1 << S_CYC) : 3'(1 << S_RUN);
                end else if (fsm_q[S_CYC] || finish) begin
                        fsm_d = 3'(1 << S_IDLE);
                end
        end

        always_ff @(posedge eph1 or negedge rst_n) begin
                if (!rst_n) begin
                        fsm_q  <= 3'(1 << S_IDLE);
                        mode_q <= MODE_NONE;
                        op_q   <= `OP_NOP;
                        prev_q <= `OP_NOP;
                        go_q   <= 1'b0;
                        tv_q   <= 1'b0;
                end else begin
                        fsm_q <= fsm_d;
                        // Permutation kicks off the cycle after acceptance
                        go_q  <= accept && (cmd.op != `OP_CYC);
                        // Text is registered on the finishing edge
                        tv_q  <= finish && is_text;
                        if (accept) begin
                                op_q <= cmd.op;
                        end
                        if (accept && (cmd.op == `OP_CYC)) begin
                                mode_q <= cmd.hash_sel ? MODE_HASH : MODE_KEYED;
                                prev_q <= `OP_NOP;
                        end else if (finish) begin
                                prev_q <= op_q;
                        end
                end
        end

        // Control bundle
        always_comb begin
                ctrl.load_cyc = fsm_q[S_CYC];
                ctrl.perm_go  = go_q;
                ctrl.op       = op_q;
                ctrl.new_op   = (op_q != prev_q);
                ctrl.mode     = mode_q;
        end

        assign textout_valid = tv_q;

        // Permutation only completes under a running command
        a_done_busy: assert property (@(posedge eph1) disable iff (!rst_n)
                perm_done |-> !fsm_q[S_IDLE]);

endmodule

/* cyclist_datapath.sv */
`timescale 1ns/1ps
`include "xoodyak_macros.svh"

module cyclist_datapath (
        input  logic                    eph1,
        input  logic                    rst_n,
        input  logic                    ready,
        input  logic [`XOO_DATA_W-1:0]  input_data,
        input  xoodyak_pkg::xoo_ctrl_t  ctrl,
        input  logic                    perm_done,
        input  xoodyak_pkg::xoo_state_t perm_state,
        output xoodyak_pkg::xoo_state_t perm_in,
        output logic                    perm_go,
        output logic [`XOO_TEXT_W-1:0]  textout
);
        import xoodyak_pkg::*;

        // Padding bit positions after crypt and squeeze
        localparam int CRYPT_PAD_BIT = `XOO_STATE_W - `XOO_TEXT_W - 8;
        localparam int SQZ_PAD_BIT   = `XOO_STATE_W - `XOO_PLANE_W - 8;

        logic [`XOO_DATA_W-1:0]  din_q;
        logic [`XOO_PLANE_W-1:0] key;
        logic [`XOO_TEXT_W-1:0]  text_in;
        logic [`XOO_TEXT_W-1:0]  text_x;
        logic [`XOO_TEXT_W-1:0]  crypt_hi;
        logic [`XOO_TEXT_W-1:0]  text_d;
        logic                    text_we;
        logic [7:0]              cu;
        xoo_state_t              state_q;
        xoo_state_t              state_cyc;
        xoo_state_t              down_abs;
        xoo_state_t              down_crypt;
        xoo_state_t              down_sqz;
        xoo_state_t              state_d;

        // Data is taken on the same edge as the command
        always_ff @(posedge eph1) begin
                if (ready) begin
                        din_q <= input_data;
                end
        end

        // MSB-aligned fields of the input
        assign key     = din_q[`XOO_DATA_W-1 -: `XOO_PLANE_W];
        assign text_in = din_q[`XOO_DATA_W-1 -: `XOO_TEXT_W];

        // Initial state, key plus id length and the keyed Cd
        assign state_cyc = (ctrl.mode == MODE_HASH) ? '0 :
                {key, 8'h01, {(`XOO_STATE_W - `XOO_PLANE_W - 16){1'b0}}, 8'h02};

        // ------------------------------
        // Up side
        // ------------------------------
        // Cu only on the first of a run of equal ops
        always_comb begin
                cu = 8'h00;
                if (ctrl.new_op) begin
                        if ((ctrl.op == `OP_ENC) || (ctrl.op == `OP_DEC)) begin
                                cu = 8'h80;
                        end else if ((ctrl.op == `OP_SQZ) && (ctrl.mode == MODE_KEYED)) begin
                                cu = 8'h40;
                        end
                end
        end

        assign perm_in = state_q ^ xoo_state_t'(cu);
        assign perm_go = ctrl.perm_go;

        // ------------------------------
        // Down side on the permutation result
        // ------------------------------
        always_comb begin
                if (ctrl.mode == MODE_HASH) begin
                        // Hash rate is one plane
                        down_abs = perm_state ^ {key, 8'h01,
                                {(`XOO_STATE_W - `XOO_PLANE_W - 8){1'b0}}};
                end else begin
                        // Keyed rate, Cd of 0x03 on a fresh absorb
                        down_abs = perm_state ^ {din_q, 8'h01, 16'h0000,
                                (ctrl.new_op ? 8'h03 : 8'h00)};
                end
        end

        // Keystream mix, ciphertext on encrypt and plaintext on decrypt
        assign text_x   = text_in ^ perm_state[`XOO_STATE_W-1 -: `XOO_TEXT_W];
        // Rate always ends up holding the ciphertext
        assign crypt_hi = (ctrl.op == `OP_ENC) ? text_x : text_in;

        assign down_crypt = {crypt_hi, perm_state[`XOO_STATE_W-`XOO_TEXT_W-1:0]}
                ^ (xoo_state_t'(1) << CRYPT_PAD_BIT);
        assign down_sqz   = perm_state ^ (xoo_state_t'(1) << SQZ_PAD_BIT);

        always_comb begin
                case (ctrl.op)
                        `OP_ABS: state_d = down_abs;
                        `OP_ENC,
                        `OP_DEC: state_d = down_crypt;
                        `OP_SQZ: state_d = down_sqz;
                        default: state_d = state_q;
                endcase
        end

        always_ff @(posedge eph1) begin
                if (ctrl.load_cyc) begin
                        state_q <= state_cyc;
                end else if (perm_done) begin
                        state_q <= state_d;
                end
        end

        // Text output, squeeze gives one plane padded with zeros
        assign text_d  = (ctrl.op == `OP_SQZ) ?
                {perm_state[`XOO_STATE_W-1 -: `XOO_PLANE_W],
                 {(`XOO_TEXT_W - `XOO_PLANE_W){1'b0}}} : text_x;
        assign text_we = perm_done && (ctrl.op inside {`OP_ENC, `OP_DEC, `OP_SQZ});

        always_ff @(posedge eph1 or negedge rst_n) begin
                if (!rst_n) begin
                        textout <= '0;
                end else if (text_we) begin
                        textout <= text_d;
                end
        end

endmodule

/* xoodyak_top.sv */
`timescale 1ns/1ps
`include "xoodyak_macros.svh"

module xoodyak_top (
        input  logic                   eph1,
        input  logic                   rst_n,
        input  logic [`XOO_DATA_W-1:0] input_data,
        input  xoodyak_pkg::xoo_cmd_t  opmode,
        output logic                   ready,
        output logic [`XOO_TEXT_W-1:0] textout,
        output logic                   textout_valid
);
        import xoodyak_pkg::*;

        xoo_ctrl_t  ctrl;
        xoo_state_t perm_in;
        xoo_state_t perm_state;
        logic       perm_go;
        logic       perm_done;

        // Command sequencing
        cyclist_ctrl u_ctrl (
                .eph1          (eph1),
                .rst_n         (rst_n),
                .cmd           (opmode),
                .perm_done     (perm_done),
                .ctrl          (ctrl),
                .ready         (ready),
                .textout_valid (textout_valid)
        );

        // State, up and down functions
        cyclist_datapath u_dp (
                .eph1       (eph1),
                .rst_n      (rst_n),
                .ready      (ready),
                .input_data (input_data),
                .ctrl       (ctrl),
                .perm_done  (perm_done),
                .perm_state (perm_state),
                .perm_in    (perm_in),
                .perm_go    (perm_go),
                .textout    (textout)
        );

        // Xoodoo, four clocks per call
        xoodoo_permute u_perm (
                .eph1      (eph1),
                .rst_n     (rst_n),
                .go        (perm_go),
                .state_in  (perm_in),
                .state_out (perm_state),
                .done      (perm_done)
        );

endmodule

/* tb_xoodyak_model.svh */
`ifndef TB_XOODYAK_MODEL_SVH
`define TB_XOODYAK_MODEL_SVH

// ------------------------------
// Reference Xoodoo permutation
// ------------------------------
// Round constants in order of use
localparam logic [11:0] MODEL_RC [12] = '{
        12'h058, 12'h038, 12'h3C0, 12'h0D0, 12'h120, 12'h014,
        12'h060, 12'h02C, 12'h380, 12'h0F0, 12'h1A0, 12'h012
};

// Model cyclist modes
localparam logic [1:0] M_NONE  = 2'd0;
localparam logic [1:0] M_HASH  = 2'd1;
localparam logic [1:0] M_KEYED = 2'd2;

// Model state, mode and last completed op
logic [`XOO_STATE_W-1:0] m_state;
logic [1:0]              m_mode;
logic [3:0]              m_prev;

function automatic logic [31:0] rotl32(input logic [31:0] v, input int n);
        if (n == 0) begin
                return v;
        end
        return (v << n) | (v >> (32 - n));
endfunction

// One round on a [y][x] lane array
function automatic logic [`XOO_STATE_W-1:0] ref_round(input logic [`XOO_STATE_W-1:0] s,
                input logic [11:0] rc);
        logic [31:0]             a [3][4];
        logic [31:0]             b [3][4];
        logic [31:0]             p [4];
        logic [31:0]             e [4];
        logic [`XOO_STATE_W-1:0] res;
        for (int y = 0; y < 3; y++) begin
                for (int x = 0; x < 4; x++) begin
                        a[y][x] = s[128*y + 32*x +: 32];
                end
        end
        // Theta, column parity folded back from the lane before
        for (int x = 0; x < 4; x++) begin
                p[x] = a[0][x] ^ a[1][x] ^ a[2][x];
        end
        for (int x = 0; x < 4; x++) begin
                e[x] = rotl32(p[(x + 3) % 4], 5) ^ rotl32(p[(x + 3) % 4], 14);
        end
        // Rho west, plane 1 takes lane x-1, plane 2 rotates by 11
        for (int x = 0; x < 4; x++) begin
                b[0][x] = a[0][x] ^ e[x];
                b[1][x] = a[1][(x + 3) % 4] ^ e[(x + 3) % 4];
                b[2][x] = rotl32(a[2][x] ^ e[x], 11);
        end
        // Iota
        b[0][0] = b[0][0] ^ {20'h00000, rc};
        // Chi
        for (int x = 0; x < 4; x++) begin
                a[0][x] = b[0][x] ^ (~b[1][x] & b[2][x]);
                a[1][x] = b[1][x] ^ (~b[2][x] & b[0][x]);
                a[2][x] = b[2][x] ^ (~b[0][x] & b[1][x]);
        end
        // Rho east, plane 2 moves two lanes
        for (int x = 0; x < 4; x++) begin
                res[32*x +: 32]       = a[0][x];
                res[128 + 32*x +: 32] = rotl32(a[1][x], 1);
                res[256 + 32*x +: 32] = rotl32(a[2][(x + 2) % 4], 8);
        end
        return res;
endfunction

function automatic logic [`XOO_STATE_W-1:0] ref_permute(input logic [`XOO_STATE_W-1:0] s);
        logic [`XOO_STATE_W-1:0] t;
        t = s;
        for (int i = 0; i < `XOO_ROUNDS; i++) begin
                t = ref_round(t, MODEL_RC[i]);
        end
        return t;
endfunction

// ------------------------------
// Cyclist rules
// ------------------------------
function automatic logic ref_legal(input logic [3:0] op);
        logic ok;
        case (op)
                `OP_CYC: ok = 1'b1;
                `OP_ABS,
                `OP_SQZ: ok = (m_mode != M_NONE);
                `OP_ENC,
                `OP_DEC: ok = (m_mode == M_KEYED);
                default: ok = 1'b0;
        endcase
        return ok;
endfunction

// Cu on the up side, only for a fresh op
function automatic logic [7:0] ref_cu(input logic [3:0] op, input logic fresh);
        logic [7:0] cu;
        cu = 8'h00;
        if (fresh && ((op == `OP_ENC) || (op == `OP_DEC))) begin
                cu = 8'h80;
        end else if (fresh && (op == `OP_SQZ) && (m_mode == M_KEYED)) begin
                cu = 8'h40;
        end
        return cu;
endfunction

// Apply one accepted command to the model
function automatic void ref_exec(input logic [3:0] op, input logic hash_sel,
                input logic [`XOO_DATA_W-1:0] data, output logic text_en,
                output logic [`XOO_TEXT_W-1:0] text);
        logic [`XOO_STATE_W-1:0] res;
        logic                    fresh;
        text_en = 1'b0;
        text    = '0;
        fresh   = (op != m_prev);
        if (op == `OP_CYC) begin
                m_mode  = hash_sel ? M_HASH : M_KEYED;
                m_prev  = `OP_NOP;
                m_state = '0;
                if (!hash_sel) begin
                        m_state[383:256] = data[351:224];
                        m_state[255:248] = 8'h01;
                        m_state[7:0]     = 8'h02;
                end
                return;
        end
        res = ref_permute(m_state ^ {376'h0, ref_cu(op, fresh)});
        m_state = res;
        case (op)
                `OP_ABS: begin
                        if (m_mode == M_HASH) begin
                                m_state[383:256] = res[383:256] ^ data[351:224];
                                m_state[255:248] = res[255:248] ^ 8'h01;
                        end else begin
                                m_state[383:32] = res[383:32] ^ data;
                                m_state[31:24]  = res[31:24] ^ 8'h01;
                                // Keyed absorb marks a fresh block with 0x03
                                if (fresh) begin
                                        m_state[7:0] = res[7:0] ^ 8'h03;
                                end
                        end
                end
                `OP_ENC,
                `OP_DEC: begin
                        text             = data[351:160] ^ res[383:192];
                        m_state[383:192] = (op == `OP_ENC) ? text : data[351:160];
                        m_state[184]     = ~res[184];
                        text_en          = 1'b1;
                end
                `OP_SQZ: begin
                        text         = {res[383:256], 64'h0};
                        m_state[248] = ~res[248];
                        text_en      = 1'b1;
                end
                default: begin
                        m_state = res;
                end
        endcase
        m_prev = op;
endfunction

`endif

/* tb_xoodyak.sv */
`timescale 1ns/1ps
`include "xoodyak_macros.svh"

module tb_xoodyak;
        import xoodyak_pkg::*;

        localparam int SEED        = 45871;
        localparam int N_RANDOM    = 200;
        localparam int N_DIRECTED  = 21;
        // Seven clocks per command from drive to next drive plus one spare
        localparam int CYC_PER_CMD = 8;
        localparam int CYC_LIMIT   = (N_RANDOM + N_DIRECTED) * CYC_PER_CMD + 100;

        logic                   eph1;
        logic                   rst_n;
        logic [`XOO_DATA_W-1:0] input_data;
        xoo_cmd_t               opmode;
        logic                   ready;
        logic [`XOO_TEXT_W-1:0] textout;
        logic                   textout_valid;
        int                     cycles;

        `include "tb_xoodyak_model.svh"

        xoodyak_top dut0 (
                .eph1          (eph1),
                .rst_n         (rst_n),
                .input_data    (input_data),
                .opmode        (opmode),
                .ready         (ready),
                .textout       (textout),
                .textout_valid (textout_valid)
        );

        // 40 ns clock
        always #20 eph1 = ~eph1;

        // ------------------------------
        // Watchdog
        // ------------------------------
        always @(posedge eph1) begin
                cycles <= cycles + 1;
                if (cycles >= CYC_LIMIT) begin
                        $display("Run did not finish within %0d clock cycles", CYC_LIMIT);
                        $display("TEST FAILED");
                        $fatal(1, "timeout");
                end
        end

        task automatic stop_on_error(input string msg);
                $display("ERROR at %0t ns: %s", $time, msg);
                $display("TEST FAILED");
                $fatal(1, "check failed");
        endtask

        // Eleven random words for one data block
        function automatic logic [`XOO_DATA_W-1:0] rand_data();
                logic [`XOO_DATA_W-1:0] d;
                for (int i = 0; i < `XOO_DATA_W / 32; i++) begin
                        d[32*i +: 32] = $urandom;
                end
                return d;
        endfunction

        // Drive one command, follow it to completion, check latency and text
        task automatic run_cmd(input logic [3:0] op, input logic hash_sel,
                        input logic [`XOO_DATA_W-1:0] data, output logic [`XOO_TEXT_W-1:0] text);
                logic                   legal;
                logic                   text_en;
                logic [`XOO_TEXT_W-1:0] exp_text;
                int                     low;
                int                     exp_low;
                legal = ref_legal(op);
                @(posedge eph1);
                opmode     <= xoo_cmd_t'({hash_sel, op});
                input_data <= data;
                @(negedge eph1);
                assert (ready && !textout_valid) else
                        stop_on_error("engine not idle with textout_valid low before a command");
                // Acceptance edge
                @(posedge eph1);
                opmode <= xoo_cmd_t'({1'b0, `OP_NOP});
                text_en  = 1'b0;
                exp_text = '0;
                exp_low  = 0;
                if (legal) begin
                        ref_exec(op, hash_sel, data, text_en, exp_text);
                        exp_low = (op == `OP_CYC) ? 1 : 5;
                end
                low = 0;
                @(negedge eph1);
                while (!ready) begin
                        assert (!textout_valid) else
                                stop_on_error("textout_valid high while busy");
                        low++;
                        @(negedge eph1);
                end
                assert (low == exp_low) else
                        stop_on_error($sformatf("op %0d held ready low %0d cycles, expected %0d",
                                op, low, exp_low));
                assert (textout_valid == text_en) else
                        stop_on_error($sformatf("op %0d textout_valid %b, expected %b",
                                op, textout_valid, text_en));
                if (text_en) begin
                        assert (textout == exp_text) else
                                stop_on_error($sformatf("op %0d textout %h, expected %h",
                                        op, textout, exp_text));
                end
                text = textout;
        endtask

        initial begin
                logic [`XOO_DATA_W-1:0] key;
                logic [`XOO_DATA_W-1:0] ad;
                logic [`XOO_DATA_W-1:0] pt;
                logic [`XOO_TEXT_W-1:0] ct;
                logic [`XOO_TEXT_W-1:0] out;
                logic [`XOO_TEXT_W-1:0] sqz_a;
                logic [`XOO_TEXT_W-1:0] sqz_b;
                logic [3:0]             op;
                logic [3:0]             last_op;
                int                     r;
                void'($urandom(SEED));
                eph1       = 1'b0;
                rst_n      = 1'b0;
                input_data = '0;
                opmode     = '0;
                cycles     = 0;
                m_state    = '0;
                m_mode     = M_NONE;
                m_prev     = `OP_NOP;
                repeat (16) @(posedge eph1);
                rst_n <= 1'b1;
                @(negedge eph1);
                assert (ready && !textout_valid && (textout == '0)) else
                        stop_on_error("outputs not at reset values");

                // Only cyclist may start before a mode is set
                run_cmd(`OP_ABS, 1'b0, rand_data(), out);
                run_cmd(`OP_SQZ, 1'b1, rand_data(), out);
                run_cmd(`OP_ENC, 1'b0, rand_data(), out);
                run_cmd(`OP_DEC, 1'b0, rand_data(), out);
                run_cmd(4'd2, 1'b0, rand_data(), out);
                run_cmd(4'd9, 1'b1, rand_data(), out);

                // ------------------------------
                // Hash sequence with an encrypt that hash mode ignores
                // ------------------------------
                run_cmd(`OP_CYC, 1'b1, rand_data(), out);
                run_cmd(`OP_ABS, 1'b1, rand_data(), out);
                run_cmd(`OP_ABS, 1'b1, rand_data(), out);
                run_cmd(`OP_SQZ, 1'b1, rand_data(), out);
                run_cmd(`OP_SQZ, 1'b1, rand_data(), out);
                run_cmd(`OP_ENC, 1'b0, rand_data(), out);
                run_cmd(`OP_SQZ, 1'b0, rand_data(), out);

                // Keyed encrypt then a squeeze of the resulting state
                key = rand_data();
                ad  = rand_data();
                pt  = rand_data();
                run_cmd(`OP_CYC, 1'b0, key, out);
                run_cmd(`OP_ABS, 1'b0, ad, out);
                run_cmd(`OP_ENC, 1'b0, pt, ct);
                run_cmd(`OP_SQZ, 1'b0, rand_data(), sqz_a);

                // Same history then decrypt of the ciphertext
                run_cmd(`OP_CYC, 1'b0, key, out);
                run_cmd(`OP_ABS, 1'b0, ad, out);
                run_cmd(`OP_DEC, 1'b0, {ct, {(`XOO_DATA_W - `XOO_TEXT_W){1'b0}}}, out);
                assert (out == pt[`XOO_DATA_W-1 -: `XOO_TEXT_W]) else
                        stop_on_error($sformatf("decrypt gave %h, expected %h",
                                out, pt[`XOO_DATA_W-1 -: `XOO_TEXT_W]));
                run_cmd(`OP_SQZ, 1'b0, rand_data(), sqz_b);
                assert (sqz_b == sqz_a) else
                        stop_on_error($sformatf("squeeze after decrypt %h, after encrypt %h",
                                sqz_b, sqz_a));

                // ------------------------------
                // Random mix with back to back repeats
                // ------------------------------
                last_op = `OP_NOP;
                for (int i = 0; i < N_RANDOM; i++) begin
                        r = $urandom % 32;
                        if ((r < 10) && (last_op != `OP_NOP)) begin
                                op = last_op;
                        end else if (r < 13) begin
                                op = `OP_CYC;
                        end else if (r < 17) begin
                                op = `OP_ABS;
                        end else if (r < 21) begin
                                op = `OP_ENC;
                        end else if (r < 25) begin
                                op = `OP_DEC;
                        end else if (r < 29) begin
                                op = `OP_SQZ;
                        end else begin
                                // Any opcode and mostly illegal ones
                                op = 4'($urandom);
                        end
                        run_cmd(op, 1'($urandom), rand_data(), out);
                        last_op = op;
                end

                $display("TEST OK");
                $finish;
        end

endmodule

/* sources.f */
+incdir+.
xoodyak_pkg.sv
xoodoo_round.sv
xoodoo_permute.sv
cyclist_ctrl.sv
cyclist_datapath.sv
xoodyak_top.sv
tb_xoodyak.sv

/* run.sh */
#!/usr/bin/env bash
# Build the Xoodyak testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
        --top-module tb_xoodyak \
        -f sources.f \
        -o sim_xoodyak

./obj_dir/sim_xoodyak
